//--- common/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// general register count
`define RV_NREGS 32

// implemented machine csrs
`define RV_CSR_MSTATUS  12'h300
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MEPC     12'h341

`endif

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // data, address and result word
    typedef logic [31:0] word_t;

    // general register index
    typedef logic [4:0] reg_addr_t;

    // csr address space
    typedef logic [11:0] csr_addr_t;

    // one value per decoded instruction
    typedef enum logic [5:0] {
        OP_UNKNOWN,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        // address only, no memory behind it
        OP_LOAD,
        OP_STORE,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_CSRRWI,
        OP_CSRRSI,
        OP_CSRRCI
    } inst_op_e;

endpackage

`default_nettype wire

//--- decode/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_pkg::*;
(
    input  word_t     instr_i,
    output inst_op_e  op_o,
    output reg_addr_t rd_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output csr_addr_t csr_o,
    output word_t     imm_o
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i_fmt;
    word_t      imm_s_fmt;
    word_t      imm_b_fmt;
    word_t      imm_u_fmt;
    word_t      imm_j_fmt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // fixed field positions
    assign rd_o  = instr_i[11:7];
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign csr_o = instr_i[31:20];

    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        op_o  = OP_UNKNOWN;
        imm_o = '0;
        case (opcode)
            OPC_LUI: begin
                op_o  = OP_LUI;
                imm_o = imm_u_fmt;
            end
            OPC_AUIPC: begin
                op_o  = OP_AUIPC;
                imm_o = imm_u_fmt;
            end
            OPC_JAL: begin
                op_o  = OP_JAL;
                imm_o = imm_j_fmt;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) op_o = OP_JALR;
                imm_o = imm_i_fmt;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op_o = OP_BEQ;
                    3'b001:  op_o = OP_BNE;
                    3'b100:  op_o = OP_BLT;
                    3'b101:  op_o = OP_BGE;
                    3'b110:  op_o = OP_BLTU;
                    3'b111:  op_o = OP_BGEU;
                    default: op_o = OP_UNKNOWN;
                endcase
                imm_o = imm_b_fmt;
            end
            OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) op_o = OP_LOAD;
                imm_o = imm_i_fmt;
            end
            OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) op_o = OP_STORE;
                imm_o = imm_s_fmt;
            end
            OPC_OPIMM: begin
                imm_o = imm_i_fmt;
                case (funct3)
                    3'b000: op_o = OP_ADDI;
                    3'b010: op_o = OP_SLTI;
                    3'b011: op_o = OP_SLTIU;
                    3'b100: op_o = OP_XORI;
                    3'b110: op_o = OP_ORI;
                    3'b111: op_o = OP_ANDI;
                    3'b001: begin
                        if (funct7 == 7'h00) op_o = OP_SLLI;
                        imm_o = {27'b0, instr_i[24:20]};
                    end
                    default: begin
                        if (funct7 == 7'h00) op_o = OP_SRLI;
                        else if (funct7 == 7'h20) op_o = OP_SRAI;
                        imm_o = {27'b0, instr_i[24:20]};
                    end
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op_o = OP_ADD;
                    {7'h20, 3'b000}: op_o = OP_SUB;
                    {7'h00, 3'b001}: op_o = OP_SLL;
                    {7'h00, 3'b010}: op_o = OP_SLT;
                    {7'h00, 3'b011}: op_o = OP_SLTU;
                    {7'h00, 3'b100}: op_o = OP_XOR;
                    {7'h00, 3'b101}: op_o = OP_SRL;
                    {7'h20, 3'b101}: op_o = OP_SRA;
                    {7'h00, 3'b110}: op_o = OP_OR;
                    {7'h00, 3'b111}: op_o = OP_AND;
                    default:         op_o = OP_UNKNOWN;
                endcase
            end
            OPC_SYSTEM: begin
                // funct3 000 is ecall/ebreak, left as unknown
                case (funct3)
                    3'b001:  op_o = OP_CSRRW;
                    3'b010:  op_o = OP_CSRRS;
                    3'b011:  op_o = OP_CSRRC;
                    3'b101:  op_o = OP_CSRRWI;
                    3'b110:  op_o = OP_CSRRSI;
                    3'b111:  op_o = OP_CSRRCI;
                    default: op_o = OP_UNKNOWN;
                endcase
            end
            default: begin
                op_o  = OP_UNKNOWN;
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- execute/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute
    import rv_pkg::*;
(
    input  inst_op_e  op_i,
    input  reg_addr_t rs1_i,
    input  word_t     operand1_i,
    input  word_t     operand2_i,
    input  word_t     imm_i,
    input  word_t     pc_i,
    output word_t     alu_result_o,
    output word_t     alu_result_2_o,
    output logic      branch_taken_o,
    output logic      jump_o,
    output logic      write_reg_o,
    output logic      write_csr_o
);

    word_t      zimm;
    logic [4:0] shamt_reg;
    logic [4:0] shamt_imm;
    logic       cond;
    logic       csr_src_zero;

    // csr immediate forms carry a 5-bit value in the rs1 field
    assign zimm         = {27'b0, rs1_i};
    assign csr_src_zero = (rs1_i == 5'd0);
    assign shamt_reg    = operand2_i[4:0];
    assign shamt_imm    = imm_i[4:0];

    // branch condition
    always_comb begin
        case (op_i)
            OP_BEQ:  cond = (operand1_i == operand2_i);
            OP_BNE:  cond = (operand1_i != operand2_i);
            OP_BLT:  cond = ($signed(operand1_i) < $signed(operand2_i));
            OP_BGE:  cond = ($signed(operand1_i) >= $signed(operand2_i));
            OP_BLTU: cond = (operand1_i < operand2_i);
            OP_BGEU: cond = (operand1_i >= operand2_i);
            default: cond = 1'b0;
        endcase
    end

    // primary result, the value for rd
    always_comb begin
        case (op_i)
            OP_ADD:   alu_result_o = operand1_i + operand2_i;
            OP_SUB:   alu_result_o = operand1_i - operand2_i;
            OP_XOR:   alu_result_o = operand1_i ^ operand2_i;
            OP_OR:    alu_result_o = operand1_i | operand2_i;
            OP_AND:   alu_result_o = operand1_i & operand2_i;
            OP_SLL:   alu_result_o = operand1_i << shamt_reg;
            OP_SRL:   alu_result_o = operand1_i >> shamt_reg;
            OP_SRA:   alu_result_o = $signed(operand1_i) >>> shamt_reg;
            OP_SLT:   alu_result_o = {31'b0, $signed(operand1_i) < $signed(operand2_i)};
            OP_SLTU:  alu_result_o = {31'b0, operand1_i < operand2_i};
            OP_XORI:  alu_result_o = operand1_i ^ imm_i;
            OP_ORI:   alu_result_o = operand1_i | imm_i;
            OP_ANDI:  alu_result_o = operand1_i & imm_i;
            OP_SLLI:  alu_result_o = operand1_i << shamt_imm;
            OP_SRLI:  alu_result_o = operand1_i >> shamt_imm;
            OP_SRAI:  alu_result_o = $signed(operand1_i) >>> shamt_imm;
            OP_SLTI:  alu_result_o = {31'b0, $signed(operand1_i) < $signed(imm_i)};
            OP_SLTIU: alu_result_o = {31'b0, operand1_i < imm_i};
            // loads and stores only form the address here
            OP_ADDI, OP_LOAD, OP_STORE: alu_result_o = operand1_i + imm_i;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                alu_result_o = {31'b0, cond};
            OP_JAL, OP_JALR: alu_result_o = pc_i + 32'd4;
            OP_LUI:   alu_result_o = imm_i;
            OP_AUIPC: alu_result_o = pc_i + imm_i;
            // old csr value arrives on operand2
            OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI:
                alu_result_o = operand2_i;
            default:  alu_result_o = '0;
        endcase
    end

    // secondary result, the jump target or new csr value
    always_comb begin
        case (op_i)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_JAL:
                alu_result_2_o = pc_i + imm_i;
            OP_JALR:   alu_result_2_o = (operand1_i + imm_i) & ~32'd1;
            OP_CSRRW:  alu_result_2_o = operand1_i;
            OP_CSRRS:  alu_result_2_o = operand2_i | operand1_i;
            OP_CSRRC:  alu_result_2_o = operand2_i & ~operand1_i;
            OP_CSRRWI: alu_result_2_o = zimm;
            OP_CSRRSI: alu_result_2_o = operand2_i | zimm;
            OP_CSRRCI: alu_result_2_o = operand2_i & ~zimm;
            default:   alu_result_2_o = '0;
        endcase
    end

    assign branch_taken_o = cond;
    assign jump_o         = (op_i inside {OP_JAL, OP_JALR});

    assign write_reg_o = !(op_i inside {OP_UNKNOWN, OP_LOAD, OP_STORE,
                                        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                        OP_BLTU, OP_BGEU});

    // set/clear with a zero source is a pure read
    assign write_csr_o = (op_i inside {OP_CSRRW, OP_CSRRWI}) ||
                         ((op_i inside {OP_CSRRS, OP_CSRRC, OP_CSRRSI, OP_CSRRCI}) &&
                          !csr_src_zero);

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module reg_file
    import rv_pkg::*;
(
    input  logic      i_clk,
    input  logic      reset_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t waddr_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [`RV_NREGS];

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired to zero
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module csr_file
    import rv_pkg::*;
(
    input  logic      i_clk,
    input  logic      reset_i,
    input  csr_addr_t addr_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rdata_o
);

    word_t mstatus;
    word_t mtvec;
    word_t mscratch;
    word_t mepc;

    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
        end else if (we_i) begin
            case (addr_i)
                `RV_CSR_MSTATUS:  mstatus  <= wdata_i;
                // base must stay word aligned
                `RV_CSR_MTVEC:    mtvec    <= {wdata_i[31:2], 2'b00};
                `RV_CSR_MSCRATCH: mscratch <= wdata_i;
                `RV_CSR_MEPC:     mepc     <= wdata_i;
                default: begin
                    // unimplemented address, write dropped
                end
            endcase
        end
    end

    always_comb begin
        case (addr_i)
            `RV_CSR_MSTATUS:  rdata_o = mstatus;
            `RV_CSR_MTVEC:    rdata_o = mtvec;
            `RV_CSR_MSCRATCH: rdata_o = mscratch;
            `RV_CSR_MEPC:     rdata_o = mepc;
            default:          rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core
    import rv_pkg::*;
(
    input  logic      i_clk,
    input  logic      reset_i,
    input  logic      en_i,
    input  word_t     instr_i,
    output logic      done_o,
    output logic      rd_wr_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output word_t     pc_o
);

    inst_op_e  op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    csr_addr_t csr_addr;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     csr_rdata;
    word_t     operand2;
    word_t     alu_result;
    word_t     alu_result_2;
    logic      branch_taken;
    logic      jump;
    logic      write_reg;
    logic      write_csr;
    logic      is_csr;
    word_t     pc_q;

    inst_decoder u_decoder (
        .instr_i (instr_i),
        .op_o    (op),
        .rd_o    (rd),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .csr_o   (csr_addr),
        .imm_o   (imm)
    );

    reg_file u_reg_file (
        .i_clk    (i_clk),
        .reset_i  (reset_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .waddr_i  (rd),
        .we_i     (en_i & write_reg),
        .wdata_i  (alu_result),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    csr_file u_csr_file (
        .i_clk   (i_clk),
        .reset_i (reset_i),
        .addr_i  (csr_addr),
        .we_i    (en_i & write_csr),
        .wdata_i (alu_result_2),
        .rdata_o (csr_rdata)
    );

    // csr ops see the old csr value on operand2
    assign is_csr   = (op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                  OP_CSRRWI, OP_CSRRSI, OP_CSRRCI});
    assign operand2 = is_csr ? csr_rdata : rs2_data;

    execute u_execute (
        .op_i           (op),
        .rs1_i          (rs1),
        .operand1_i     (rs1_data),
        .operand2_i     (operand2),
        .imm_i          (imm),
        .pc_i           (pc_q),
        .alu_result_o   (alu_result),
        .alu_result_2_o (alu_result_2),
        .branch_taken_o (branch_taken),
        .jump_o         (jump),
        .write_reg_o    (write_reg),
        .write_csr_o    (write_csr)
    );

    // pc and writeback report
    always_ff @(posedge i_clk) begin
        if (reset_i) begin
            pc_q    <= '0;
            done_o  <= 1'b0;
            rd_wr_o <= 1'b0;
        end else begin
            done_o  <= en_i;
            rd_wr_o <= en_i & write_reg;
            if (en_i) begin
                pc_q <= (branch_taken || jump) ? alu_result_2 : pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (en_i) begin
            rd_addr_o <= rd;
            rd_data_o <= alu_result;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- testbench/wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wb_checker
    import rv_pkg::*;
(
    input  logic         i_clk,
    input  logic         reset_i,
    input  logic         done_i,
    input  logic         rd_wr_i,
    input  reg_addr_t    rd_addr_i,
    input  word_t        rd_data_i,
    input  word_t        pc_i,
    input  logic         push_i,
    input  logic [127:0] exp_name_i,
    input  logic         exp_rd_wr_i,
    input  reg_addr_t    exp_rd_addr_i,
    input  word_t        exp_rd_data_i,
    input  word_t        exp_pc_i,
    output int           pending_o,
    output int           mismatches_o,
    output int           unexpected_o
);

    // rows accepted by the dut and not yet reported
    logic [127:0] name_q [$];
    logic         wr_q [$];
    reg_addr_t    rd_q [$];
    word_t        data_q [$];
    word_t        pc_q [$];

    task automatic compare_word(input logic [127:0] row, input string field,
                                input word_t expected, input word_t actual);
        if (actual !== expected) begin
            mismatches_o++;
            $display("ERR %0s %s expected %h actual %h", row, field, expected, actual);
        end
    endtask

    always @(posedge i_clk) begin
        logic [127:0] row;
        logic         exp_wr;
        reg_addr_t    exp_rd;
        word_t        exp_data;
        word_t        exp_pc;
        if (reset_i) begin
            name_q.delete();
            wr_q.delete();
            rd_q.delete();
            data_q.delete();
            pc_q.delete();
            mismatches_o = 0;
            unexpected_o = 0;
        end else begin
            // en_i sampled at this edge, so the row is now in flight
            if (push_i) begin
                name_q.push_back(exp_name_i);
                wr_q.push_back(exp_rd_wr_i);
                rd_q.push_back(exp_rd_addr_i);
                data_q.push_back(exp_rd_data_i);
                pc_q.push_back(exp_pc_i);
            end
            if (done_i) begin
                if (name_q.size() == 0) begin
                    unexpected_o++;
                    $display("done_o raised at pc %h with no table row waiting for it", pc_i);
                end else begin
                    row      = name_q.pop_front();
                    exp_wr   = wr_q.pop_front();
                    exp_rd   = rd_q.pop_front();
                    exp_data = data_q.pop_front();
                    exp_pc   = pc_q.pop_front();
                    compare_word(row, "rd_wr_o", {31'b0, exp_wr}, {31'b0, rd_wr_i});
                    if (exp_wr) begin
                        compare_word(row, "rd_addr_o", {27'b0, exp_rd}, {27'b0, rd_addr_i});
                        compare_word(row, "rd_data_o", exp_data, rd_data_i);
                    end
                    compare_word(row, "pc_o", exp_pc, pc_i);
                end
            end
        end
        pending_o = name_q.size();
    end

endmodule

`default_nettype wire

//--- testbench/tb_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core
    import rv_pkg::*;
();

    localparam int OPC_OP    = 'h33;
    localparam int OPC_OPIMM = 'h13;
    localparam int OPC_LUI   = 'h37;
    localparam int OPC_AUIPC = 'h17;
    localparam int OPC_JALR  = 'h67;

    logic         clk;
    logic         reset;
    logic         en;
    word_t        instr;
    logic         done;
    logic         rd_wr;
    reg_addr_t    rd_addr;
    word_t        rd_data;
    word_t        pc;
    logic [127:0] exp_name;
    logic         exp_rd_wr;
    reg_addr_t    exp_rd_addr;
    word_t        exp_rd_data;
    word_t        exp_pc;
    int           pending;
    int           mismatches;
    int           unexpected;

    logic [127:0] name_tab [64];
    word_t        instr_tab [64];
    logic         wr_tab [64];
    reg_addr_t    rd_tab [64];
    word_t        val_tab [64];
    word_t        pc_tab [64];
    int           n_rows;
    int           cycles;
    int           timeout_limit;
    logic [31:0]  rng;

    exec_core uut (
        .i_clk     (clk),
        .reset_i   (reset),
        .en_i      (en),
        .instr_i   (instr),
        .done_o    (done),
        .rd_wr_o   (rd_wr),
        .rd_addr_o (rd_addr),
        .rd_data_o (rd_data),
        .pc_o      (pc)
    );

    wb_checker u_checker (
        .i_clk         (clk),
        .reset_i       (reset),
        .done_i        (done),
        .rd_wr_i       (rd_wr),
        .rd_addr_i     (rd_addr),
        .rd_data_i     (rd_data),
        .pc_i          (pc),
        .push_i        (en),
        .exp_name_i    (exp_name),
        .exp_rd_wr_i   (exp_rd_wr),
        .exp_rd_addr_i (exp_rd_addr),
        .exp_rd_data_i (exp_rd_data),
        .exp_pc_i      (exp_pc),
        .pending_o     (pending),
        .mismatches_o  (mismatches),
        .unexpected_o  (unexpected)
    );

    // rv32i encodings
    function automatic word_t r_type(input int f7, input int f3, input int rd,
                                     input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP[6:0]};
    endfunction

    function automatic word_t i_type(input int opc, input int f3, input int rd,
                                     input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t u_type(input int opc, input int rd, input int upper);
        return {upper[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t b_type(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic word_t j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic word_t csr_type(input int f3, input int rd, input int src, input int csr);
        return {csr[11:0], src[4:0], f3[2:0], rd[4:0], 7'h73};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic [127:0] name, input word_t word, input logic wr,
                           input reg_addr_t rd, input word_t val, input word_t pc_after);
        name_tab[n_rows]  = name;
        instr_tab[n_rows] = word;
        wr_tab[n_rows]    = wr;
        rd_tab[n_rows]    = rd;
        val_tab[n_rows]   = val;
        pc_tab[n_rows]    = pc_after;
        n_rows++;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            if (cycles >= timeout_limit) begin
                $display("timeout after %0d cycles, %0d table rows never reported",
                         cycles, pending);
                $display("** FAIL **");
                $finish;
            end
        end
    end

    initial begin
        reset       = 1'b1;
        en          = 1'b0;
        instr       = '0;
        exp_name    = '0;
        exp_rd_wr   = 1'b0;
        exp_rd_addr = '0;
        exp_rd_data = '0;
        exp_pc      = '0;
        n_rows      = 0;
        rng         = 32'h1841_fc0e;

        // x1 = 5, x2 = -3
        add_row("addi x1", i_type(OPC_OPIMM, 0, 1, 0, 5), 1'b1, 5'd1, 32'd5, 32'd4);
        add_row("addi x2", i_type(OPC_OPIMM, 0, 2, 0, -3), 1'b1, 5'd2, 32'hffff_fffd, 32'd8);
        add_row("add", r_type('h00, 0, 3, 1, 2), 1'b1, 5'd3, 32'd2, 32'd12);
        add_row("sub", r_type('h20, 0, 4, 1, 2), 1'b1, 5'd4, 32'd8, 32'd16);
        add_row("and", r_type('h00, 7, 5, 1, 2), 1'b1, 5'd5, 32'd5, 32'd20);
        add_row("or", r_type('h00, 6, 6, 1, 2), 1'b1, 5'd6, 32'hffff_fffd, 32'd24);
        add_row("xor", r_type('h00, 4, 7, 1, 2), 1'b1, 5'd7, 32'hffff_fff8, 32'd28);
        add_row("sll", r_type('h00, 1, 8, 1, 1), 1'b1, 5'd8, 32'h0000_00a0, 32'd32);
        add_row("srl", r_type('h00, 5, 9, 2, 1), 1'b1, 5'd9, 32'h07ff_ffff, 32'd36);
        add_row("sra", r_type('h20, 5, 10, 2, 1), 1'b1, 5'd10, 32'hffff_ffff, 32'd40);
        add_row("slt neg", r_type('h00, 2, 11, 2, 1), 1'b1, 5'd11, 32'd1, 32'd44);
        add_row("sltu neg", r_type('h00, 3, 12, 2, 1), 1'b1, 5'd12, 32'd0, 32'd48);
        add_row("srai", i_type(OPC_OPIMM, 5, 13, 2, 'h401), 1'b1, 5'd13, 32'hffff_fffe, 32'd52);
        add_row("addi x0", i_type(OPC_OPIMM, 0, 0, 1, 7), 1'b1, 5'd0, 32'd12, 32'd56);
        add_row("read x0", r_type('h00, 0, 14, 0, 1), 1'b1, 5'd14, 32'd5, 32'd60);
        add_row("lui", u_type(OPC_LUI, 15, 'h12345), 1'b1, 5'd15, 32'h1234_5000, 32'd64);
        add_row("auipc", u_type(OPC_AUIPC, 16, 1), 1'b1, 5'd16, 32'h0000_1040, 32'd68);
        add_row("beq taken", b_type(0, 1, 1, 8), 1'b0, 5'd0, 32'd0, 32'd76);
        add_row("beq not", b_type(0, 1, 2, 8), 1'b0, 5'd0, 32'd0, 32'd80);
        add_row("bne taken", b_type(1, 1, 2, 8), 1'b0, 5'd0, 32'd0, 32'd88);
        add_row("bne not", b_type(1, 1, 1, 8), 1'b0, 5'd0, 32'd0, 32'd92);
        add_row("blt taken", b_type(4, 2, 1, 8), 1'b0, 5'd0, 32'd0, 32'd100);
        add_row("blt not", b_type(4, 1, 2, 8), 1'b0, 5'd0, 32'd0, 32'd104);
        add_row("bge taken", b_type(5, 1, 2, 8), 1'b0, 5'd0, 32'd0, 32'd112);
        add_row("bge not", b_type(5, 2, 1, 8), 1'b0, 5'd0, 32'd0, 32'd116);
        add_row("bltu taken", b_type(6, 1, 2, 8), 1'b0, 5'd0, 32'd0, 32'd124);
        add_row("bltu not", b_type(6, 2, 1, 8), 1'b0, 5'd0, 32'd0, 32'd128);
        add_row("bgeu taken", b_type(7, 2, 1, 8), 1'b0, 5'd0, 32'd0, 32'd136);
        add_row("bgeu not", b_type(7, 1, 2, 8), 1'b0, 5'd0, 32'd0, 32'd140);
        add_row("jal", j_type(17, 16), 1'b1, 5'd17, 32'd144, 32'd156);
        add_row("addi x18", i_type(OPC_OPIMM, 0, 18, 0, 256), 1'b1, 5'd18, 32'd256, 32'd160);
        add_row("jalr", i_type(OPC_JALR, 0, 19, 18, 8), 1'b1, 5'd19, 32'd164, 32'd264);
        add_row("jal back", j_type(0, -64), 1'b1, 5'd0, 32'd268, 32'd200);
        // mscratch then mtvec, low two bits of mtvec stay clear
        add_row("csrrw", csr_type(1, 20, 1, 'h340), 1'b1, 5'd20, 32'd0, 32'd204);
        add_row("csrrs rd1", csr_type(2, 21, 0, 'h340), 1'b1, 5'd21, 32'd5, 32'd208);
        add_row("csrrs", csr_type(2, 22, 2, 'h340), 1'b1, 5'd22, 32'd5, 32'd212);
        add_row("csrrc", csr_type(3, 23, 1, 'h340), 1'b1, 5'd23, 32'hffff_fffd, 32'd216);
        add_row("csrrs rd2", csr_type(2, 24, 0, 'h340), 1'b1, 5'd24, 32'hffff_fff8, 32'd220);
        add_row("csrrwi", csr_type(5, 25, 23, 'h305), 1'b1, 5'd25, 32'd0, 32'd224);
        add_row("csrrsi", csr_type(6, 26, 3, 'h305), 1'b1, 5'd26, 32'd20, 32'd228);
        add_row("csrrci", csr_type(7, 27, 4, 'h305), 1'b1, 5'd27, 32'd20, 32'd232);
        add_row("csrrs rd3", csr_type(2, 28, 0, 'h305), 1'b1, 5'd28, 32'd16, 32'd236);
        add_row("csrrw none", csr_type(1, 29, 1, 'h7c0), 1'b1, 5'd29, 32'd0, 32'd240);
        add_row("csrrs none", csr_type(2, 30, 0, 'h7c0), 1'b1, 5'd30, 32'd0, 32'd244);
        add_row("fence", 32'h0000_000f, 1'b0, 5'd0, 32'd0, 32'd248);
        add_row("add back", r_type('h00, 0, 31, 29, 21), 1'b1, 5'd31, 32'd5, 32'd252);

        // one row and one possible gap per two cycles, plus drain
        timeout_limit = n_rows * 2 + 20;

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        for (int k = 0; k < n_rows; k++) begin
            rng = xorshift32(rng);
            if (rng[1:0] == 2'b00) begin
                @(posedge clk);
                en <= 1'b0;
            end
            @(posedge clk);
            en          <= 1'b1;
            instr       <= instr_tab[k];
            exp_name    <= name_tab[k];
            exp_rd_wr   <= wr_tab[k];
            exp_rd_addr <= rd_tab[k];
            exp_rd_data <= val_tab[k];
            exp_pc      <= pc_tab[k];
        end
        @(posedge clk);
        en <= 1'b0;

        // wait for the last reports
        do begin
            @(negedge clk);
        end while (pending != 0);

        $display("mismatches %0d, unexpected reports %0d, missing reports %0d",
                 mismatches, unexpected, pending);
        if (mismatches == 0 && unexpected == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/rv_pkg.sv
decode/inst_decoder.sv
execute/execute.sv
logic/reg_file.sv
logic/csr_file.sv
logic/exec_core.sv
testbench/wb_checker.sv
testbench/tb_exec_core.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --top-module tb_exec_core -f flist.f -o sim_exec_core > build.log 2>&1 \
    && ./obj_dir/sim_exec_core > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0
